// File: bench/commit_window_asserts.sv
// Concurrent checks on the commit window outputs that the testbench attaches with bind
`timescale 1ns/1ps
`default_nettype none

`include "commit_params.svh"

module commit_window_asserts (
	input wire                           clk,
	input wire                           reset,
	input wire [`COMMIT_IDX_W-1:0]       commit_start,
	input wire [`COMMIT_IDX_W:0]         commit_available,
	input wire [`COMMIT_DEPTH-1:0]       ready_mask,
	input wire commit_pkg::write_port_t  write_ports [`WRITE_PORTS]
);

	localparam int DEPTH = `COMMIT_DEPTH;
	localparam int IDX_W = `COMMIT_IDX_W;
	localparam int PORTS = `WRITE_PORTS;

	// number of failed checks so far
	int violations = 0;

	logic [DEPTH-1:0] occupied;
	logic dup_grant;

	// slots from the start pointer that hold an entry
	always_comb begin
		logic [IDX_W-1:0] slot;
		int occ;
		occupied = '0;
		occ = DEPTH - int'(commit_available);
		for (int i = 0; i < DEPTH; i++) begin
			slot = commit_start + IDX_W'(i);
			if (i < occ) begin
				occupied[slot] = 1'b1;
			end
		end
	end

	always_comb begin
		dup_grant = 1'b0;
		for (int a = 0; a < PORTS; a++) begin
			for (int b = a + 1; b < PORTS; b++) begin
				if (write_ports[a].valid && write_ports[b].valid &&
						write_ports[a].index == write_ports[b].index) begin
					dup_grant = 1'b1;
				end
			end
		end
	end

	available_in_range: assert property (@(posedge clk) disable iff (reset)
		commit_available <= (IDX_W+1)'(DEPTH))
		else begin
			$error("commit_available exceeds the window depth");
			violations = violations + 1;
		end

	ready_inside_ring: assert property (@(posedge clk) disable iff (reset)
		(ready_mask & ~occupied) == '0)
		else begin
			$error("ready set on a slot outside the occupied ring");
			violations = violations + 1;
		end

	grants_unique: assert property (@(posedge clk) disable iff (reset) !dup_grant)
		else begin
			$error("two write ports granted to the same entry");
			violations = violations + 1;
		end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
// Free-running clock for the commit window testbench, instantiated once by the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD_NS = 50
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	// 100 ns period
	always begin
		#(HALF_PERIOD_NS) clk = ~clk;
	end

endmodule

`default_nettype wire

// File: bench/tb_commit_window.sv
// Testbench top that checks the commit window against a cycle model under random stimulus
`timescale 1ns/1ps
`default_nettype none

`include "commit_params.svh"

module tb_commit_window;

	localparam int DEPTH = `COMMIT_DEPTH;
	localparam int IDX_W = `COMMIT_IDX_W;
	localparam int REG_W = `REG_IDX_W;
	localparam int PORTS = `WRITE_PORTS;
	localparam int RETIRE_W = `RETIRE_WIDTH;
	localparam int RESET_CYCLES = 16;
	localparam int FILL_LIMIT = 4 * DEPTH;
	localparam int DRAIN_LIMIT = 400;
	localparam int RANDOM_CYCLES = 4000;

	logic clk;
	logic reset;
	logic dispatch;
	commit_pkg::commit_op_t dispatch_op;
	logic [DEPTH-1:0] schedule;
	logic branch_fix;
	logic [IDX_W-1:0] branch_fix_index;
	logic [IDX_W-1:0] commit_start;
	logic [IDX_W-1:0] commit_end;
	logic [IDX_W:0] commit_available;
	logic [`RETIRE_CNT_W-1:0] num_retired;
	logic [DEPTH-1:0] ready_mask;
	logic [DEPTH-1:0] completed_mask;
	commit_pkg::write_port_t write_ports [PORTS];

	integer seed = 32'h0257_2a86;

	// ring model with the count of occupied slots and per-slot state
	int m_start;
	int m_count;
	logic [DEPTH-1:0] m_valid;
	logic [DEPTH-1:0] m_sched;
	logic [DEPTH-1:0] m_completed;
	logic [DEPTH-1:0] m_req;
	logic [DEPTH-1:0] m_done;
	int m_age [DEPTH];
	commit_pkg::commit_op_t m_op [DEPTH];

	// predictions for the current cycle
	logic [DEPTH-1:0] exp_ready;
	logic [DEPTH-1:0] exp_ack;
	commit_pkg::write_port_t exp_ports [PORTS];
	int exp_retired;

	tb_clock u_clock (
		.clk(clk)
	);

	commit_window u_dut (
		.clk(clk),
		.reset(reset),
		.dispatch(dispatch),
		.dispatch_op(dispatch_op),
		.schedule(schedule),
		.branch_fix(branch_fix),
		.branch_fix_index(branch_fix_index),
		.commit_start(commit_start),
		.commit_end(commit_end),
		.commit_available(commit_available),
		.num_retired(num_retired),
		.ready_mask(ready_mask),
		.completed_mask(completed_mask),
		.write_ports(write_ports)
	);

	bind commit_window commit_window_asserts u_asserts (
		.clk(clk),
		.reset(reset),
		.commit_start(commit_start),
		.commit_available(commit_available),
		.ready_mask(ready_mask),
		.write_ports(write_ports)
	);

	task automatic stop_with_failure();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_index(string what, logic [IDX_W-1:0] got, logic [IDX_W-1:0] exp);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_count(string what, logic [IDX_W:0] got, logic [IDX_W:0] exp);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_mask(string what, logic [DEPTH-1:0] got, logic [DEPTH-1:0] exp);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s is %b, expected %b", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_port(string what, commit_pkg::write_port_t got,
			commit_pkg::write_port_t exp);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s is valid %b index %0d rd %0d, expected %b %0d %0d",
				$time, what, got.valid, got.index, got.rd, exp.valid, exp.index, exp.rd);
			stop_with_failure();
		end
	endtask

	function automatic int rand_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic tag_ok(commit_pkg::src_tag_t t);
		return !t.pending || m_completed[t.num[IDX_W-1:0]];
	endfunction

	// a producer that was granted or has written back no longer holds the operand
	function automatic commit_pkg::src_tag_t resolve_tag(commit_pkg::src_tag_t t,
			logic [DEPTH-1:0] written);
		commit_pkg::src_tag_t r;
		r = t;
		if (t.pending && written[t.num[IDX_W-1:0]]) begin
			r.pending = 1'b0;
		end
		return r;
	endfunction

	// half of the sources wait on a live entry when there is one
	function automatic commit_pkg::src_tag_t make_tag();
		commit_pkg::src_tag_t t;
		int slot;
		t.pending = 1'b0;
		t.num = REG_W'(rand_below(1 << REG_W));
		if (m_count > 0 && rand_below(2) == 1) begin
			slot = (m_start + rand_below(m_count)) % DEPTH;
			t.pending = 1'b1;
			t.num = REG_W'(slot);
		end
		return t;
	endfunction

	task automatic clear_entry(int i);
		m_valid[i] = 1'b0;
		m_sched[i] = 1'b0;
		m_completed[i] = 1'b0;
		m_req[i] = 1'b0;
		m_done[i] = 1'b0;
		m_age[i] = 0;
	endtask

	task automatic predict();
		int slot;
		int granted;
		exp_ready = '0;
		for (int i = 0; i < DEPTH; i++) begin
			if (m_valid[i] && !m_sched[i] && tag_ok(m_op[i].rs1) &&
					(!m_op[i].needs_rs2 || tag_ok(m_op[i].rs2))) begin
				exp_ready[i] = 1'b1;
			end
		end
		// grants go to the oldest requesters up to the first unfinished entry
		exp_ack = '0;
		for (int p = 0; p < PORTS; p++) begin
			exp_ports[p] = '0;
		end
		granted = 0;
		for (int k = 0; k < DEPTH; k++) begin
			slot = (m_start + k) % DEPTH;
			if (!m_req[slot] && !m_done[slot]) begin
				break;
			end
			if (m_req[slot] && granted < PORTS) begin
				exp_ack[slot] = 1'b1;
				exp_ports[granted].valid = 1'b1;
				exp_ports[granted].index = IDX_W'(slot);
				exp_ports[granted].rd = m_op[slot].rd;
				granted = granted + 1;
			end
		end
		exp_retired = 0;
		while (exp_retired < RETIRE_W && m_done[(m_start + exp_retired) % DEPTH]) begin
			exp_retired = exp_retired + 1;
		end
	endtask

	task automatic compare_outputs();
		if (u_dut.u_asserts.violations != 0) begin
			$display("an assertion on the DUT failed before time %0t", $time);
			stop_with_failure();
		end
		check_index("commit_start", commit_start, IDX_W'(m_start));
		check_index("commit_end", commit_end, IDX_W'((m_start + m_count) % DEPTH));
		check_count("commit_available", commit_available, (IDX_W+1)'(DEPTH - m_count));
		check_count("num_retired", (IDX_W+1)'(num_retired), (IDX_W+1)'(exp_retired));
		check_mask("ready_mask", ready_mask, exp_ready);
		check_mask("completed_mask", completed_mask, m_completed);
		for (int p = 0; p < PORTS; p++) begin
			check_port($sformatf("write_ports[%0d]", p), write_ports[p], exp_ports[p]);
		end
	endtask

	// one clock edge of the model given this cycle's state and inputs
	task automatic advance(input bit disp, input commit_pkg::commit_op_t op,
			input logic [DEPTH-1:0] sched, input bit fix, input int fix_idx);
		logic [DEPTH-1:0] written;
		logic [DEPTH-1:0] killed;
		logic [DEPTH-1:0] retiring;
		int kept;
		int load_slot;
		int comp_at;
		int fin;
		written = exp_ack | m_done;
		killed = '0;
		retiring = '0;
		kept = 0;
		if (fix) begin
			kept = (fix_idx - m_start + DEPTH) % DEPTH + 1;
			for (int k = 0; k < m_count - kept; k++) begin
				killed[(fix_idx + 1 + k) % DEPTH] = 1'b1;
			end
		end
		for (int k = 0; k < exp_retired; k++) begin
			retiring[(m_start + k) % DEPTH] = 1'b1;
		end
		load_slot = (m_start + m_count) % DEPTH;
		for (int i = 0; i < DEPTH; i++) begin
			comp_at = (m_op[i].unit == commit_pkg::mul) ? 1 + `MUL_EXTRA : 1;
			fin = comp_at + 2;
			m_op[i].rs1 = resolve_tag(m_op[i].rs1, written);
			m_op[i].rs2 = resolve_tag(m_op[i].rs2, written);
			if (killed[i] || retiring[i]) begin
				clear_entry(i);
			end else if (disp && i == load_slot) begin
				clear_entry(i);
				m_valid[i] = 1'b1;
				m_op[i] = op;
				m_op[i].rs1 = resolve_tag(op.rs1, written);
				m_op[i].rs2 = resolve_tag(op.rs2, written);
			end else if (m_valid[i]) begin
				if (sched[i]) begin
					m_sched[i] = 1'b1;
					m_age[i] = 1;
					m_completed[i] = (comp_at == 1);
				end else if (m_sched[i] && m_age[i] < fin) begin
					m_age[i] = m_age[i] + 1;
					if (m_age[i] == comp_at) begin
						m_completed[i] = 1'b1;
					end
					if (m_age[i] == fin) begin
						if (m_op[i].makes_rd) begin
							m_req[i] = 1'b1;
						end else begin
							m_done[i] = 1'b1;
						end
					end
				end
				if (exp_ack[i]) begin
					m_req[i] = 1'b0;
					m_done[i] = 1'b1;
				end
			end
		end
		m_start = (m_start + exp_retired) % DEPTH;
		if (fix) begin
			m_count = kept - exp_retired;
		end else begin
			m_count = m_count + int'(disp) - exp_retired;
		end
	endtask

	task automatic run_cycle(input int dispatch_pct, input int sched_pct, input bit may_fix);
		commit_pkg::commit_op_t op;
		logic [DEPTH-1:0] sched;
		int candidates[$];
		bit do_fix;
		bit do_disp;
		int fix_idx;
		int slot;
		@(posedge clk);
		#1;
		predict();
		do_fix = 1'b0;
		fix_idx = 0;
		// a branch fix names a live entry that has not finished
		if (may_fix && rand_below(20) == 0) begin
			for (int k = 0; k < m_count; k++) begin
				slot = (m_start + k) % DEPTH;
				if (!m_done[slot]) begin
					candidates.push_back(slot);
				end
			end
			if (candidates.size() > 0) begin
				do_fix = 1'b1;
				fix_idx = candidates[rand_below(candidates.size())];
			end
		end
		do_disp = !do_fix && m_count < DEPTH && rand_below(100) < dispatch_pct;
		op = '0;
		if (do_disp) begin
			case (rand_below(3))
				0: op.unit = commit_pkg::alu;
				1: op.unit = commit_pkg::branch;
				default: op.unit = commit_pkg::mul;
			endcase
			op.rs1 = make_tag();
			op.rs2 = make_tag();
			op.needs_rs2 = rand_below(2) == 1;
			op.rd = REG_W'(rand_below(1 << REG_W));
			op.makes_rd = rand_below(4) != 0;
		end
		sched = '0;
		for (int i = 0; i < DEPTH; i++) begin
			if (exp_ready[i] && rand_below(100) < sched_pct) begin
				sched[i] = 1'b1;
			end
		end
		dispatch = do_disp;
		dispatch_op = op;
		schedule = sched;
		branch_fix = do_fix;
		branch_fix_index = IDX_W'(fix_idx);
		#10;
		compare_outputs();
		advance(do_disp, op, sched, do_fix, fix_idx);
	endtask

	// dispatch without scheduling until the DUT shows a full ring
	task automatic fill_ring();
		int cycles;
		cycles = 0;
		while (commit_available != 0) begin
			if (cycles == FILL_LIMIT) begin
				$display("timeout: the ring did not fill within %0d cycles", FILL_LIMIT);
				stop_with_failure();
			end
			run_cycle(100, 0, 1'b0);
			cycles = cycles + 1;
		end
	endtask

	task automatic drain_ring();
		int cycles;
		cycles = 0;
		while (commit_available != (IDX_W+1)'(DEPTH)) begin
			if (cycles == DRAIN_LIMIT) begin
				$display("timeout: the ring did not empty within %0d cycles", DRAIN_LIMIT);
				stop_with_failure();
			end
			run_cycle(0, 60, 1'b0);
			cycles = cycles + 1;
		end
	endtask

	initial begin
		reset = 1'b1;
		dispatch = 1'b0;
		dispatch_op = '0;
		schedule = '0;
		branch_fix = 1'b0;
		branch_fix_index = '0;
		m_start = 0;
		m_count = 0;
		for (int i = 0; i < DEPTH; i++) begin
			clear_entry(i);
			m_op[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		#10;
		predict();
		compare_outputs();
		fill_ring();
		drain_ring();
		repeat (RANDOM_CYCLES) run_cycle(70, 50, 1'b1);
		drain_ring();
		if (u_dut.u_asserts.violations == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("%0d assertion failures were reported", u_dut.u_asserts.violations);
			stop_with_failure();
		end
	end

endmodule

`default_nettype wire

// File: commit_window.f
+incdir+logic
logic/commit_pkg.sv
logic/commit_ring_ctrl.sv
logic/commit_entry.sv
logic/commit_retire_sel.sv
logic/commit_window.sv
bench/tb_clock.sv
bench/commit_window_asserts.sv
bench/tb_commit_window.sv

// File: logic/commit_entry.sv
// One commit window slot: holds a dispatched instruction and sequences it to commit
`timescale 1ns/1ps
`default_nettype none

`include "commit_params.svh"

module commit_entry (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          load,
	input  wire                          kill,
	input  wire                          ended,
	input  wire commit_pkg::commit_op_t  op,
	input  wire                          schedule,
	input  wire [`COMMIT_DEPTH-1:0]      completed_in,
	input  wire [`COMMIT_DEPTH-1:0]      ack_in,
	input  wire [`COMMIT_DEPTH-1:0]      done_in,
	input  wire                          commit_ack,
	output logic                         ready,
	output logic                         completed,
	output logic                         commit_req,
	output logic                         done,
	output logic [`REG_IDX_W-1:0]        write_rd
);

	localparam int DEPTH = `COMMIT_DEPTH;
	localparam int IDX_W = `COMMIT_IDX_W;
	localparam int EXTRA_W = $clog2(`MUL_EXTRA + 1);

	commit_pkg::commit_op_t op_r;

	logic valid;
	logic busy;
	logic busy2;
	logic [EXTRA_W-1:0] extra;

	// producers that have been granted a write port or have written back
	logic [DEPTH-1:0] written_mask;

	function automatic logic src_written(commit_pkg::src_tag_t t, logic [DEPTH-1:0] mask);
		return t.pending && mask[t.num[IDX_W-1:0]];
	endfunction

	function automatic logic src_ok(commit_pkg::src_tag_t t, logic [DEPTH-1:0] mask);
		return !t.pending || mask[t.num[IDX_W-1:0]];
	endfunction

	assign written_mask = ack_in | done_in;
	assign write_rd = op_r.rd;

	// not yet scheduled means neither busy nor completed
	assign ready = valid && !busy && !completed &&
		src_ok(op_r.rs1, completed_in) &&
		(!op_r.needs_rs2 || src_ok(op_r.rs2, completed_in));

	// state sequence: busy, (mul extra cycles), busy2, then commit_req or done
	always_ff @(posedge clk) begin
		if (reset || kill || ended) begin
			valid <= 1'b0;
			busy <= 1'b0;
			busy2 <= 1'b0;
			extra <= '0;
			completed <= 1'b0;
			commit_req <= 1'b0;
			done <= 1'b0;
		end else if (load) begin
			valid <= 1'b1;
			busy <= 1'b0;
			busy2 <= 1'b0;
			extra <= '0;
			completed <= 1'b0;
			commit_req <= 1'b0;
			done <= 1'b0;
		end else if (valid) begin
			if (schedule) begin
				busy <= 1'b1;
				busy2 <= 1'b0;
				if (op_r.unit == commit_pkg::mul) begin
					extra <= EXTRA_W'(`MUL_EXTRA);
					completed <= 1'b0;
				end else begin
					extra <= '0;
					completed <= 1'b1;
				end
			end else if (busy && !busy2) begin
				if (extra != '0) begin
					extra <= extra - 1'b1;
					// result becomes bypassable on the last multiply cycle
					if (extra == EXTRA_W'(1)) begin
						completed <= 1'b1;
					end
				end else begin
					busy2 <= 1'b1;
				end
			end else if (busy && busy2) begin
				busy <= 1'b0;
				busy2 <= 1'b0;
				if (op_r.makes_rd) begin
					commit_req <= 1'b1;
				end else begin
					done <= 1'b1;
				end
			end
			if (commit_req && commit_ack) begin
				commit_req <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// once a producer writes back, the operand comes from the register file,
	// so a retired and reused producer slot never holds up this entry
	always_ff @(posedge clk) begin
		if (load) begin
			op_r <= op;
			if (src_written(op.rs1, written_mask)) begin
				op_r.rs1.pending <= 1'b0;
			end
			if (src_written(op.rs2, written_mask)) begin
				op_r.rs2.pending <= 1'b0;
			end
		end else begin
			if (src_written(op_r.rs1, written_mask)) begin
				op_r.rs1.pending <= 1'b0;
			end
			if (src_written(op_r.rs2, written_mask)) begin
				op_r.rs2.pending <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/commit_params.svh
// Sizes of the commit window, included by the package and by every commit module
`ifndef COMMIT_PARAMS_SVH
`define COMMIT_PARAMS_SVH

// number of commit entries in the ring
`define COMMIT_DEPTH 8

// bits that index one entry
`define COMMIT_IDX_W 3

// architectural register number width
`define REG_IDX_W 5

// register write ports granted per cycle
`define WRITE_PORTS 2

// most entries retired in one cycle
`define RETIRE_WIDTH 4

// width of the retire count, 0 to RETIRE_WIDTH
`define RETIRE_CNT_W $clog2(`RETIRE_WIDTH + 1)

// extra busy cycles a multiply spends before it completes
`define MUL_EXTRA 2

`endif

// File: logic/commit_pkg.sv
// Types shared by the commit window modules and its testbench
`default_nettype none

`include "commit_params.svh"

package commit_pkg;

	// execution unit of a dispatched instruction
	typedef enum logic [1:0] {
		alu    = 2'd0,
		branch = 2'd1,
		mul    = 2'd2
	} unit_t;

	// source operand tag
	// while pending, the low bits of num name the producing entry,
	// otherwise the operand is read from the register file
	typedef struct packed {
		logic                  pending;
		logic [`REG_IDX_W-1:0] num;
	} src_tag_t;

	// one dispatched instruction as it enters a commit entry
	typedef struct packed {
		unit_t                 unit;
		src_tag_t              rs1;
		src_tag_t              rs2;
		logic                  needs_rs2;
		logic [`REG_IDX_W-1:0] rd;
		logic                  makes_rd;
	} commit_op_t;

	// one register write port grant
	typedef struct packed {
		logic                     valid;
		logic [`COMMIT_IDX_W-1:0] index;
		logic [`REG_IDX_W-1:0]    rd;
	} write_port_t;

endpackage

`default_nettype wire

// File: logic/commit_retire_sel.sv
// In-order write port grant and retire count for the commit window
`timescale 1ns/1ps
`default_nettype none

`include "commit_params.svh"

module commit_retire_sel (
	input  wire [`COMMIT_IDX_W-1:0]      commit_start,
	input  wire [`COMMIT_DEPTH-1:0]      commit_req,
	input  wire [`COMMIT_DEPTH-1:0]      done,
	input  wire [`REG_IDX_W-1:0]         entry_rd [`COMMIT_DEPTH],
	output logic [`COMMIT_DEPTH-1:0]     commit_ack,
	output commit_pkg::write_port_t      write_ports [`WRITE_PORTS],
	output logic [`RETIRE_CNT_W-1:0]     num_retired
);

	localparam int DEPTH = `COMMIT_DEPTH;
	localparam int IDX_W = `COMMIT_IDX_W;
	localparam int PORTS = `WRITE_PORTS;
	localparam int RETIRE_W = `RETIRE_WIDTH;

	// grants follow program order and stop at the first unfinished entry
	always_comb begin
		logic [IDX_W-1:0] slot;
		logic run;
		int granted;
		commit_ack = '0;
		for (int p = 0; p < PORTS; p++) begin
			write_ports[p] = '0;
		end
		run = 1'b1;
		granted = 0;
		for (int i = 0; i < DEPTH; i++) begin
			slot = commit_start + IDX_W'(i);
			if (!commit_req[slot] && !done[slot]) begin
				run = 1'b0;
			end
			if (run && commit_req[slot] && granted < PORTS) begin
				commit_ack[slot] = 1'b1;
				write_ports[granted].valid = 1'b1;
				write_ports[granted].index = slot;
				write_ports[granted].rd = entry_rd[slot];
				granted++;
			end
		end
	end

	// run of done entries from the start, at most RETIRE_WIDTH
	always_comb begin
		logic [IDX_W-1:0] slot;
		logic run;
		num_retired = '0;
		run = 1'b1;
		for (int i = 0; i < RETIRE_W; i++) begin
			slot = commit_start + IDX_W'(i);
			if (!done[slot]) begin
				run = 1'b0;
			end
			if (run) begin
				num_retired = num_retired + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/commit_ring_ctrl.sv
// Ring pointer control of the commit window: allocation, retirement and branch rollback
`timescale 1ns/1ps
`default_nettype none

`include "commit_params.svh"

module commit_ring_ctrl (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        dispatch,
	input  wire                        branch_fix,
	input  wire [`COMMIT_IDX_W-1:0]    branch_fix_index,
	input  wire [`RETIRE_CNT_W-1:0]    num_retired,
	output logic [`COMMIT_IDX_W-1:0]   commit_start,
	output logic [`COMMIT_IDX_W-1:0]   commit_end,
	output logic [`COMMIT_IDX_W:0]     commit_available,
	output logic [`COMMIT_DEPTH-1:0]   load_mask,
	output logic [`COMMIT_DEPTH-1:0]   kill_mask,
	output logic [`COMMIT_DEPTH-1:0]   ended_mask
);

	localparam int DEPTH = `COMMIT_DEPTH;
	localparam int IDX_W = `COMMIT_IDX_W;
	localparam int RETIRE_W = `RETIRE_WIDTH;
	localparam int CNT_W = `RETIRE_CNT_W;

	// set when start and end are equal because every slot is taken
	logic full;

	logic [IDX_W-1:0] fix_end;
	logic [IDX_W:0] occupancy;
	logic [IDX_W:0] kept;
	logic [IDX_W:0] killed;
	logic [IDX_W:0] occupancy_next;

	assign fix_end = branch_fix_index + 1'b1;
	assign occupancy = full ? (IDX_W+1)'(DEPTH) : {1'b0, commit_end - commit_start};
	assign commit_available = (IDX_W+1)'(DEPTH) - occupancy;

	// entries from the start up to and including the fixed branch survive
	assign kept = {1'b0, branch_fix_index - commit_start} + 1'b1;
	assign killed = occupancy - kept;

	always_comb begin
		if (branch_fix) begin
			occupancy_next = kept - (IDX_W+1)'(num_retired);
		end else begin
			occupancy_next = occupancy + (IDX_W+1)'(dispatch) - (IDX_W+1)'(num_retired);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			commit_start <= '0;
			commit_end <= '0;
			full <= 1'b0;
		end else begin
			commit_start <= commit_start + IDX_W'(num_retired);
			if (branch_fix) begin
				commit_end <= fix_end;
			end else if (dispatch) begin
				commit_end <= commit_end + 1'b1;
			end
			full <= occupancy_next == (IDX_W+1)'(DEPTH);
		end
	end

	always_comb begin
		load_mask = '0;
		if (dispatch) begin
			load_mask[commit_end] = 1'b1;
		end
	end

	// younger entries lie from the new end up to the old end
	always_comb begin
		logic [IDX_W-1:0] slot;
		kill_mask = '0;
		for (int i = 0; i < DEPTH; i++) begin
			slot = fix_end + IDX_W'(i);
			if (branch_fix && (IDX_W+1)'(i) < killed) begin
				kill_mask[slot] = 1'b1;
			end
		end
	end

	always_comb begin
		logic [IDX_W-1:0] slot;
		ended_mask = '0;
		for (int i = 0; i < RETIRE_W; i++) begin
			slot = commit_start + IDX_W'(i);
			if (CNT_W'(i) < num_retired) begin
				ended_mask[slot] = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/commit_window.sv
// Top level of the commit window: ring control, retire selector and the entry array
`timescale 1ns/1ps
`default_nettype none

`include "commit_params.svh"

module commit_window (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          dispatch,
	input  wire commit_pkg::commit_op_t  dispatch_op,
	input  wire [`COMMIT_DEPTH-1:0]      schedule,
	input  wire                          branch_fix,
	input  wire [`COMMIT_IDX_W-1:0]      branch_fix_index,
	output logic [`COMMIT_IDX_W-1:0]     commit_start,
	output logic [`COMMIT_IDX_W-1:0]     commit_end,
	output logic [`COMMIT_IDX_W:0]       commit_available,
	output logic [`RETIRE_CNT_W-1:0]     num_retired,
	output logic [`COMMIT_DEPTH-1:0]     ready_mask,
	output logic [`COMMIT_DEPTH-1:0]     completed_mask,
	output commit_pkg::write_port_t      write_ports [`WRITE_PORTS]
);

	logic [`COMMIT_DEPTH-1:0] load_mask;
	logic [`COMMIT_DEPTH-1:0] kill_mask;
	logic [`COMMIT_DEPTH-1:0] ended_mask;
	logic [`COMMIT_DEPTH-1:0] commit_req_mask;
	logic [`COMMIT_DEPTH-1:0] done_mask;
	logic [`COMMIT_DEPTH-1:0] commit_ack;
	logic [`REG_IDX_W-1:0] entry_rd [`COMMIT_DEPTH];

	commit_ring_ctrl u_ring_ctrl (
		.clk(clk),
		.reset(reset),
		.dispatch(dispatch),
		.branch_fix(branch_fix),
		.branch_fix_index(branch_fix_index),
		.num_retired(num_retired),
		.commit_start(commit_start),
		.commit_end(commit_end),
		.commit_available(commit_available),
		.load_mask(load_mask),
		.kill_mask(kill_mask),
		.ended_mask(ended_mask)
	);

	commit_retire_sel u_retire_sel (
		.commit_start(commit_start),
		.commit_req(commit_req_mask),
		.done(done_mask),
		.entry_rd(entry_rd),
		.commit_ack(commit_ack),
		.write_ports(write_ports),
		.num_retired(num_retired)
	);

	// every entry sees the shared masks to resolve its source tags
	for (genvar i = 0; i < `COMMIT_DEPTH; i++) begin : g_entry
		commit_entry u_entry (
			.clk(clk),
			.reset(reset),
			.load(load_mask[i]),
			.kill(kill_mask[i]),
			.ended(ended_mask[i]),
			.op(dispatch_op),
			.schedule(schedule[i]),
			.completed_in(completed_mask),
			.ack_in(commit_ack),
			.done_in(done_mask),
			.commit_ack(commit_ack[i]),
			.ready(ready_mask[i]),
			.completed(completed_mask[i]),
			.commit_req(commit_req_mask[i]),
			.done(done_mask[i]),
			.write_rd(entry_rd[i])
		);
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the commit window testbench with Verilator.
# The result is taken from the simulation log.

set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_commit_window \
	-f commit_window.f \
	-Mdir obj_dir -o sim_commit_window
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/sim_commit_window +verilator+error+limit+100 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "TEST FAILED" "$log_file"; then
	echo "simulation failed"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
if ! grep -q "TEST OK" "$log_file"; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
exit 0
